// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RGB display testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rgb_display_tb -f sources.f -o rgb_display_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rgb_display_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"
exit 0

// ==== source/frame_ram.sv ====
`include "rgb_display_macros.svh"

module frame_ram (
    input  logic  rgb_clk,
    ram_if.memory ram
);

    // ------------------------------
    // Storage
    // ------------------------------
    logic [`RAM_DATA_WIDTH-1:0] mem [`RAM_DEPTH];   // Raw pixel words.

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge rgb_clk) begin
        if (ram.wr_en) begin
            mem[ram.wr_addr] <= ram.wr_data;      // Address set on falling edge.
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------
    // One cycle of latency to match the streamer pipeline.
    always_ff @(posedge rgb_clk) begin
        ram.rd_data <= mem[ram.rd_addr];          // Registered read.
    end

endmodule

// ==== source/ram_if.sv ====
`include "rgb_display_macros.svh"

// Write and read ports of the frame memory.
interface ram_if;

    logic [`RAM_ADDR_WIDTH-1:0] wr_addr;   // Write address.
    logic [`RAM_DATA_WIDTH-1:0] wr_data;   // Raw pixel word.
    logic                       wr_en;     // Write strobe.
    logic [`RAM_ADDR_WIDTH-1:0] rd_addr;   // Read address.
    logic [`RAM_DATA_WIDTH-1:0] rd_data;   // One cycle after rd_addr.

    modport writer (
        output wr_addr, wr_data, wr_en     // Capture side.
    );

    modport reader (
        output rd_addr,                    // Streamer side.
        input  rd_data
    );

    modport memory (
        input  wr_addr, wr_data, wr_en, rd_addr,
        output rd_data
    );

endinterface

// ==== source/rgb_capture.sv ====
`include "rgb_display_macros.svh"

module rgb_capture
    import rgb_display_pkg::*;
(
    input  logic        rgb_clk,
    input  logic        nrst,
    input  logic [23:0] rgb,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        capture_enable,
    ram_if.writer       ram,
    output logic        write_enable,
    output logic        stream_ready
);

    logic                       blanking;    // Either sync low.
    logic                       store;       // Pixel stored at next rise.
    logic                       stored;      // Pixel stored at last rise.
    logic                       mem_full;    // Last word written.
    logic                       at_last;     // Address on last word.
    logic [`RAM_ADDR_WIDTH-1:0] pixel_cnt;   // Pixels stored since enable.
    pixel_word_u                pix;         // Packed 5-6-5 word.

    // ------------------------------
    // Pixel packing
    // ------------------------------
    assign pix.field.red   = rgb[23:19];     // Drop low red bits.
    assign pix.field.green = rgb[15:10];     // Drop low green bits.
    assign pix.field.blue  = rgb[7:3];       // Drop low blue bits.
    assign ram.wr_data     = pix.raw;

    // ------------------------------
    // Write gating
    // ------------------------------
    assign blanking     = ~hsync | ~vsync;
    assign write_enable = ~blanking & capture_enable;   // Low in reset via enable.
    assign store        = write_enable & ~mem_full;
    assign ram.wr_en    = store;
    assign at_last      = ram.wr_addr == `RAM_ADDR_WIDTH'(`RAM_DEPTH - 1);

    // Rising edge side counts stored pixels and tracks the memory end.
    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            stored       <= 1'b0;
            mem_full     <= 1'b0;
            pixel_cnt    <= '0;
            stream_ready <= 1'b0;
        end else if (!capture_enable) begin
            stored       <= 1'b0;            // Fresh start on next enable.
            mem_full     <= 1'b0;
            pixel_cnt    <= '0;
            stream_ready <= 1'b0;
        end else begin
            stored <= store;
            if (store) begin
                pixel_cnt <= pixel_cnt + 1'b1;
                if (at_last) begin
                    mem_full <= 1'b1;        // No further writes.
                end
            end
            // Sticky once one full image is in memory.
            stream_ready <= stream_ready |
                (pixel_cnt >= `RAM_ADDR_WIDTH'(`IMAGE_SIZE * `SLICES_BEFORE_STREAM));
        end
    end

    // Falling edge side steps the address half a cycle ahead of the write.
    always_ff @(negedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            ram.wr_addr <= '0;
        end else if (!capture_enable) begin
            ram.wr_addr <= '0;               // Back to image start.
        end else if (stored && !at_last) begin
            ram.wr_addr <= ram.wr_addr + 1'b1;   // Next free word.
        end
    end

endmodule

// ==== source/rgb_display_macros.svh ====
`ifndef RGB_DISPLAY_MACROS_SVH
`define RGB_DISPLAY_MACROS_SVH

// ------------------------------
// Image geometry
// ------------------------------
`define IMAGE_WIDTH   40                             // Pixels per video line.
`define IMAGE_HEIGHT  48                             // Lines per image.
`define IMAGE_SIZE    (`IMAGE_WIDTH * `IMAGE_HEIGHT) // Pixels per image.

// ------------------------------
// Frame memory
// ------------------------------
`define IMAGE_IN_RAM          3                               // Images held.
`define RAM_DEPTH             (`IMAGE_SIZE * `IMAGE_IN_RAM)   // Words.
`define SLICES_BEFORE_STREAM  1        // Whole images before stream_ready.
`define RAM_ADDR_WIDTH        13       // Covers RAM_DEPTH.
`define RAM_DATA_WIDTH        16       // One 5-6-5 pixel.

`endif

// ==== source/rgb_display_pkg.sv ====
`include "rgb_display_macros.svh"

package rgb_display_pkg;

    // ------------------------------
    // Stored pixel word
    // ------------------------------
    // Written as colour fields by the capture side, stored raw, read back
    // as fields by the streamer.
    typedef union packed {
        logic [`RAM_DATA_WIDTH-1:0] raw;   // Memory view.
        struct packed {
            logic [4:0] red;               // Top 5 red bits.
            logic [5:0] green;             // Top 6 green bits.
            logic [4:0] blue;              // Top 5 blue bits.
        } field;
    } pixel_word_u;

    // ------------------------------
    // SPI command byte
    // ------------------------------
    localparam int CMD_CAPTURE_BIT = 0;    // Capture enable.
    localparam int CMD_DISPLAY_BIT = 1;    // Display enable.

endpackage

// ==== source/rgb_display_top.sv ====
module rgb_display_top (
    input  logic        rgb_clk,
    input  logic        nrst,
    input  logic [23:0] rgb,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        spi_sck,
    input  logic        spi_cs_n,
    input  logic        spi_mosi,
    output logic        write_enable,
    output logic        stream_ready,
    output logic [4:0]  led_r,
    output logic [4:0]  led_g,
    output logic [4:0]  led_b,
    output logic        led_valid,
    output logic        slice_start
);

    logic capture_enable;   // From the SPI command.
    logic display_enable;   // From the SPI command.

    ram_if ram ();          // Capture, memory and streamer.

    // ------------------------------
    // Command port
    // ------------------------------
    spi_control u_spi_control (
        .rgb_clk        (rgb_clk),
        .nrst           (nrst),
        .spi_sck        (spi_sck),
        .spi_cs_n       (spi_cs_n),
        .spi_mosi       (spi_mosi),
        .capture_enable (capture_enable),
        .display_enable (display_enable)
    );

    // ------------------------------
    // Video path
    // ------------------------------
    rgb_capture u_rgb_capture (
        .rgb_clk        (rgb_clk),
        .nrst           (nrst),
        .rgb            (rgb),
        .hsync          (hsync),
        .vsync          (vsync),
        .capture_enable (capture_enable),
        .ram            (ram.writer),
        .write_enable   (write_enable),
        .stream_ready   (stream_ready)
    );

    frame_ram u_frame_ram (
        .rgb_clk (rgb_clk),
        .ram     (ram.memory)
    );

    slice_streamer u_slice_streamer (
        .rgb_clk        (rgb_clk),
        .nrst           (nrst),
        .stream_ready   (stream_ready),
        .display_enable (display_enable),
        .ram            (ram.reader),
        .led_r          (led_r),
        .led_g          (led_g),
        .led_b          (led_b),
        .led_valid      (led_valid),
        .slice_start    (slice_start)
    );

endmodule

// ==== source/slice_streamer.sv ====
`include "rgb_display_macros.svh"

module slice_streamer
    import rgb_display_pkg::*;
(
    input  logic       rgb_clk,
    input  logic       nrst,
    input  logic       stream_ready,
    input  logic       display_enable,
    ram_if.reader      ram,
    output logic [4:0] led_r,
    output logic [4:0] led_g,
    output logic [4:0] led_b,
    output logic       led_valid,
    output logic       slice_start
);

    logic                                run;        // Both enables high.
    logic [$clog2(`IMAGE_HEIGHT)-1:0]    row;        // Row within slice.
    logic [$clog2(`IMAGE_WIDTH)-1:0]     col;        // Current slice.
    logic                                valid_p1;   // Read data valid.
    logic                                start_p1;   // Read data starts slice.
    pixel_word_u                         pix_rd;     // Returned word.

    assign run = stream_ready & display_enable;

    // ------------------------------
    // Address generation
    // ------------------------------
    // Column order, one address per cycle.
    assign ram.rd_addr = `RAM_ADDR_WIDTH'(row) * `RAM_ADDR_WIDTH'(`IMAGE_WIDTH)
                       + `RAM_ADDR_WIDTH'(col);

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            row <= '0;
            col <= '0;
        end else if (!run) begin
            row <= '0;                       // Restart at column 0.
            col <= '0;
        end else if (row == `IMAGE_HEIGHT - 1) begin
            row <= '0;
            if (col == `IMAGE_WIDTH - 1) begin
                col <= '0;                   // Wrap to first slice.
            end else begin
                col <= col + 1'b1;
            end
        end else begin
            row <= row + 1'b1;
        end
    end

    // ------------------------------
    // Control pipeline
    // ------------------------------
    // Stage 1 lines up with rd_data, stage 2 with the LED register.
    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            valid_p1    <= 1'b0;
            start_p1    <= 1'b0;
            led_valid   <= 1'b0;
            slice_start <= 1'b0;
        end else begin
            valid_p1    <= run;
            start_p1    <= run && row == '0;  // First pixel of column.
            led_valid   <= valid_p1;
            slice_start <= start_p1;
        end
    end

    // ------------------------------
    // Colour decode
    // ------------------------------
    assign pix_rd = ram.rd_data;

    always_ff @(posedge rgb_clk) begin
        led_r <= pix_rd.field.red;
        led_g <= pix_rd.field.green[5:1];    // Lowest green bit dropped.
        led_b <= pix_rd.field.blue;
    end

endmodule

// ==== source/spi_control.sv ====
module spi_control
    import rgb_display_pkg::*;
(
    input  logic rgb_clk,
    input  logic nrst,
    input  logic spi_sck,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic capture_enable,
    output logic display_enable
);

    logic [2:0] sck_sr;      // Two sync stages plus edge history.
    logic [2:0] cs_sr;       // Same for chip select.
    logic [1:0] mosi_sr;     // Two sync stages.
    logic       sck_rise;    // Sampling edge.
    logic       cs_fall;     // Frame start.
    logic       cs_rise;     // Frame end.
    logic       cs_active;   // Chip select low.
    logic [3:0] bit_cnt;     // Saturates at 15.
    logic [7:0] shift_reg;   // Command byte, MSB first.

    // ------------------------------
    // Pin synchronizers
    // ------------------------------
    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            sck_sr  <= '0;
            cs_sr   <= '1;           // Deselected at idle.
            mosi_sr <= '0;
        end else begin
            sck_sr  <= {sck_sr[1:0], spi_sck};
            cs_sr   <= {cs_sr[1:0], spi_cs_n};
            mosi_sr <= {mosi_sr[0], spi_mosi};
        end
    end

    assign sck_rise  = sck_sr[1] & ~sck_sr[2];
    assign cs_fall   = ~cs_sr[1] & cs_sr[2];
    assign cs_rise   = cs_sr[1] & ~cs_sr[2];
    assign cs_active = ~cs_sr[1];

    // ------------------------------
    // Byte receiver
    // ------------------------------
    always_ff @(posedge rgb_clk) begin
        if (cs_active && sck_rise) begin
            shift_reg <= {shift_reg[6:0], mosi_sr[1]};   // Same age as sck.
        end
    end

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            bit_cnt        <= '0;
            capture_enable <= 1'b0;
            display_enable <= 1'b0;
        end else begin
            if (cs_fall || cs_rise) begin
                bit_cnt <= '0;           // New frame or frame done.
            end else if (cs_active && sck_rise && bit_cnt != 4'hf) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // Only a complete byte updates the enables.
            if (cs_rise && bit_cnt == 4'd8) begin
                capture_enable <= shift_reg[CMD_CAPTURE_BIT];
                display_enable <= shift_reg[CMD_DISPLAY_BIT];
            end
        end
    end

endmodule

// ==== sources.f ====
+incdir+source
source/rgb_display_pkg.sv
source/ram_if.sv
source/rgb_capture.sv
source/frame_ram.sv
source/spi_control.sv
source/slice_streamer.sv
source/rgb_display_top.sv
verification/rgb_display_tb.sv

// ==== verification/rgb_display_tb.sv ====
`include "rgb_display_macros.svh"

module rgb_display_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SPI_HALF    = 4;     // Cycles per SCK phase.
    localparam int LINE_BLANK  = 8;     // hsync low cycles per line.
    localparam int FRAME_BLANK = 20;    // vsync low cycles per image.
    localparam int WAIT_LIMIT  = 100;   // Bound for short waits.

    logic        rgb_clk, nrst, hsync, vsync, spi_sck, spi_cs_n, spi_mosi;
    logic [23:0] rgb;
    logic        write_enable, stream_ready, led_valid, slice_start;
    logic [4:0]  led_r, led_g, led_b;

    int          seed = 69;
    logic [15:0] model_q [$];           // 5-6-5 words of captured pixels.
    int          active_cnt;            // Active pixels since capture on.
    int          pix_idx;               // Valid LED pixels seen.
    int          mon_errors, main_errors, pass_cnt, fail_cnt;
    logic        cap_expect;            // Capture enabled by command.
    logic        hold_ready;            // stream_ready must stay high.
    logic        stream_check;          // Compare LED pixels.
    logic        stream_on;             // LED stream must not pause.
    logic        ready_q;               // stream_ready one cycle ago.

    rgb_display_top rgb_display_top_inst (.*);

    always #2 rgb_clk = ~rgb_clk;       // 4 ns period.

    // ------------------------------
    // Monitor and reference model
    // ------------------------------
    always @(negedge rgb_clk) begin
        int          addr;
        logic [15:0] exp_word;
        if (nrst) begin
            if (cap_expect && hsync && vsync) begin
                assert (write_enable) else begin
                    $display("MISMATCH at %0t: write_enable low on active pixel", $time);
                    mon_errors++;
                end
            end else begin
                assert (!write_enable) else begin   // Blanking or capture off.
                    $display("MISMATCH at %0t: write_enable high, no capture", $time);
                    mon_errors++;
                end
            end
            assert (ready_q || !stream_ready || active_cnt >= `IMAGE_SIZE) else begin
                $display("MISMATCH at %0t: stream_ready rose after %0d pixels",
                         $time, active_cnt);
                mon_errors++;
            end
            assert (!(hold_ready && ready_q) || stream_ready) else begin
                $display("MISMATCH at %0t: stream_ready fell while enabled", $time);
                mon_errors++;
            end
            assert (!slice_start || led_valid) else begin
                $display("MISMATCH at %0t: slice_start without led_valid", $time);
                mon_errors++;
            end
            assert (!stream_on || led_valid) else begin
                $display("MISMATCH at %0t: LED stream paused", $time);
                mon_errors++;
            end
            if (stream_check && led_valid) begin
                // Row runs fastest in column order.
                addr = (pix_idx % `IMAGE_HEIGHT) * `IMAGE_WIDTH
                     + (pix_idx / `IMAGE_HEIGHT) % `IMAGE_WIDTH;
                if (addr >= model_q.size()) begin
                    $display("reference model holds no pixel at address %0d", addr);
                    mon_errors++;
                end else begin
                    exp_word = model_q[addr];
                    assert (led_r == exp_word[15:11] && led_g == exp_word[10:6] &&
                            led_b == exp_word[4:0]) else begin
                        $display("MISMATCH at %0t: pixel %0d got %h/%h/%h exp %h/%h/%h",
                                 $time, pix_idx, led_r, led_g, led_b,
                                 exp_word[15:11], exp_word[10:6], exp_word[4:0]);
                        mon_errors++;
                    end
                end
                assert (slice_start == (pix_idx % `IMAGE_HEIGHT == 0)) else begin
                    $display("MISMATCH at %0t: slice_start=%b on pixel %0d",
                             $time, slice_start, pix_idx);
                    mon_errors++;
                end
                pix_idx++;
            end
            if (cap_expect && hsync && vsync) begin
                model_q.push_back({rgb[23:19], rgb[15:10], rgb[7:3]});   // Top bits.
                active_cnt++;
            end
            ready_q = stream_ready;
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    function automatic int total_errors();
        return main_errors + mon_errors;
    endfunction

    // One clock of video with random rgb even in blanking.
    task automatic drive_cycle(input logic hs, input logic vs);
        int rnd;
        @(posedge rgb_clk);
        #0.5;
        rnd   = $random(seed);
        hsync = hs;
        vsync = vs;
        rgb   = rnd[23:0];
    endtask

    task automatic send_image();
        repeat (`IMAGE_HEIGHT) begin
            repeat (`IMAGE_WIDTH) drive_cycle(1'b1, 1'b1);
            repeat (LINE_BLANK) drive_cycle(1'b0, 1'b1);
        end
        repeat (FRAME_BLANK) drive_cycle(1'b1, 1'b0);   // Vertical blanking.
    endtask

    // Mode 0 frame sent MSB first while the video stays in blanking.
    task automatic send_spi(input logic [7:0] data, input int nbits);
        drive_cycle(1'b0, 1'b0);
        spi_cs_n = 1'b0;
        repeat (SPI_HALF) drive_cycle(1'b0, 1'b0);
        for (int i = 0; i < nbits; i++) begin
            spi_mosi = data[7-i];
            repeat (SPI_HALF) drive_cycle(1'b0, 1'b0);
            spi_sck = 1'b1;
            repeat (SPI_HALF) drive_cycle(1'b0, 1'b0);
            spi_sck = 1'b0;
        end
        repeat (SPI_HALF) drive_cycle(1'b0, 1'b0);
        spi_cs_n = 1'b1;
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (!write_enable && !stream_ready && !led_valid && !slice_start) else begin
            $display("MISMATCH at %0t: outputs not idle %s", $time, phase);
            main_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s, %0d errors", name, total_errors() - errs_before);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int   errs;
        int   n;
        logic ready_before;
        rgb_clk      = 1'b0;
        nrst         = 1'b0;
        rgb          = '0;
        hsync        = 1'b0;
        vsync        = 1'b0;
        spi_sck      = 1'b0;
        spi_cs_n     = 1'b1;
        spi_mosi     = 1'b0;
        cap_expect   = 1'b0;
        hold_ready   = 1'b0;
        stream_check = 1'b0;
        stream_on    = 1'b0;
        ready_q      = 1'b0;

        errs = total_errors();
        repeat (2) begin
            drive_cycle(1'b0, 1'b0);
            check_idle_outputs("in reset");
        end
        nrst = 1'b1;
        repeat (4) begin
            drive_cycle(1'b0, 1'b0);
            check_idle_outputs("after reset");
        end
        report_test("reset state", errs);

        errs = total_errors();
        send_image();                           // Capture still off.
        send_spi(8'h01, 8);
        repeat (6) drive_cycle(1'b0, 1'b0);     // Enable settles in blanking.
        cap_expect = 1'b1;
        send_image();
        report_test("capture gating", errs);

        errs = total_errors();
        n = 0;
        while (!stream_ready && n < WAIT_LIMIT) begin
            drive_cycle(1'b0, 1'b0);
            n++;
        end
        if (stream_ready) begin
            hold_ready = 1'b1;
        end else begin
            $display("timed out waiting for stream_ready to rise");
            main_errors++;
        end
        report_test("stream ready rise", errs);

        errs = total_errors();
        stream_check = 1'b1;
        send_spi(8'h03, 8);
        n = 0;
        while (!led_valid && n < WAIT_LIMIT) begin
            drive_cycle(1'b0, 1'b0);
            n++;
        end
        if (led_valid) begin
            stream_on = 1'b1;
        end else begin
            $display("timed out waiting for led_valid to rise");
            main_errors++;
        end
        repeat (2) send_image();                // Lands behind the first image.
        n = 0;
        while (pix_idx < 2 * `IMAGE_SIZE + `IMAGE_HEIGHT && n < 2 * `IMAGE_SIZE) begin
            drive_cycle(1'b0, 1'b0);
            n++;
        end
        if (pix_idx < 2 * `IMAGE_SIZE + `IMAGE_HEIGHT) begin
            $display("timed out waiting for two full LED passes");
            main_errors++;
        end
        report_test("slice contents", errs);

        errs = total_errors();
        ready_before = stream_ready;
        send_spi(8'h00, 5);                     // Short frame to be ignored.
        repeat (10) drive_cycle(1'b0, 1'b0);
        assert (stream_ready == ready_before) else begin
            $display("MISMATCH at %0t: stream_ready changed by short frame", $time);
            main_errors++;
        end
        report_test("incomplete spi frame", errs);

        errs = total_errors();
        stream_on  = 1'b0;
        hold_ready = 1'b0;
        cap_expect = 1'b0;
        send_spi(8'h00, 8);
        n = 0;
        while (stream_ready && n < 5) begin
            drive_cycle(1'b0, 1'b0);
            n++;
        end
        if (stream_ready) begin
            $display("timed out waiting for stream_ready to fall");
            main_errors++;
        end
        n = 0;
        while (led_valid && n < 5) begin
            drive_cycle(1'b0, 1'b0);
            n++;
        end
        if (led_valid) begin
            $display("timed out waiting for led_valid to fall");
            main_errors++;
        end
        stream_check = 1'b0;
        send_image();                           // No writes with capture off.
        report_test("capture off", errs);

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errors() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
